// ==== dsp16_seq.f ====
hdl/dsp16_pkg.sv
hdl/dsp16_branch_if.sv
hdl/dsp16_ctrl_if.sv
hdl/dsp16_fetch.sv
hdl/dsp16_decode.sv
hdl/dsp16_yaau.sv
hdl/dsp16_top.sv
sim/dsp16_props.sv
sim/dsp16_tb.sv

// ==== hdl/dsp16_branch_if.sv ====
// Branch controls from the decoder to the fetch stage
`timescale 1ns/1ns

interface dsp16_branch_if;
    import dsp16_pkg::*;

    logic            goto_ja;
    logic            call_ja;
    logic            goto_b;   // Return through pr
    logic            pc_halt;  // Hold pc for one cycle
    logic [PC_W-1:0] ja;       // Upper bits already cleared

    modport dec (
        output goto_ja, call_ja, goto_b, pc_halt, ja
    );

    modport fet (
        input goto_ja, call_ja, goto_b, pc_halt, ja
    );

endinterface

// ==== hdl/dsp16_ctrl_if.sv ====
// Load and store controls from the decoder to the Y address unit
`timescale 1ns/1ns

interface dsp16_ctrl_if;
    import dsp16_pkg::*;

    // One-cycle strobes
    logic              short_load;
    logic              long_load;
    logic              ram_load;
    logic              ram_store;

    // Fields registered with the strobes
    logic [2:0]        r_field;
    logic [1:0]        y_field;
    logic [1:0]        pm_sel;
    logic [SIMM_W-1:0] short_imm;
    logic [DATA_W-1:0] long_imm;  // Second word straight from the ROM

    modport dec (
        output short_load, long_load, ram_load, ram_store,
        output r_field, y_field, pm_sel, short_imm, long_imm
    );

    modport exe (
        input short_load, long_load, ram_load, ram_store,
        input r_field, y_field, pm_sel, short_imm, long_imm
    );

endinterface

// ==== hdl/dsp16_decode.sv ====
// DSP16 instruction decoder
// Turns ROM words into one-cycle strobes, tracks skipped words and RAM bubbles
`timescale 1ns/1ns

module dsp16_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  logic [dsp16_pkg::DATA_W-1:0] rom_dout,
    dsp16_branch_if.dec                 br,
    dsp16_ctrl_if.dec                   ctl,
    output logic                        fault
);
    import dsp16_pkg::*;

    dsp16_instr_u      instr;
    logic [4:0]        t_cls;       // T with the don't-care bit cleared
    logic [DATA_W-1:0] held_word;   // Word caught during a RAM bubble
    logic              use_held;
    logic              stall;
    logic              double;      // Next word is not an instruction
    logic              br_shadow;   // A branch leaves two words to drop

    assign instr        = use_held ? held_word : rom_dout;
    assign ctl.long_imm = rom_dout;  // Valid in the long_load cycle

    always_comb begin
        t_cls = instr.jump.t;
        if (t_cls[4:1] == T_GOTO_JA[4:1] ||
            t_cls[4:1] == T_SHORT_IMM[4:1] ||
            t_cls[4:1] == T_CALL_JA[4:1]) begin
            t_cls[0] = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            br.goto_ja     <= 1'b0;
            br.call_ja     <= 1'b0;
            br.goto_b      <= 1'b0;
            br.pc_halt     <= 1'b0;
            ctl.short_load <= 1'b0;
            ctl.long_load  <= 1'b0;
            ctl.ram_load   <= 1'b0;
            ctl.ram_store  <= 1'b0;
            double         <= 1'b0;
            br_shadow      <= 1'b0;
            stall          <= 1'b0;
            use_held       <= 1'b0;
            fault          <= 1'b0;
        end else if (cen) begin
            // Every strobe lasts one enabled cycle
            br.goto_ja     <= 1'b0;
            br.call_ja     <= 1'b0;
            br.goto_b      <= 1'b0;
            br.pc_halt     <= 1'b0;
            ctl.short_load <= 1'b0;
            ctl.long_load  <= 1'b0;
            ctl.ram_load   <= 1'b0;
            ctl.ram_store  <= 1'b0;
            double         <= 1'b0;
            br_shadow      <= 1'b0;
            stall          <= 1'b0;
            use_held       <= stall;  // Replay after the bubble

            if (double) begin
                double <= br_shadow;  // Second word behind a branch
            end else if (!stall) begin
                case (t_cls)
                    T_GOTO_JA: begin
                        br.goto_ja <= 1'b1;
                        double     <= 1'b1;
                        br_shadow  <= 1'b1;
                    end
                    T_CALL_JA: begin
                        br.call_ja <= 1'b1;
                        double     <= 1'b1;
                        br_shadow  <= 1'b1;
                    end
                    T_GOTO_B: begin
                        br.goto_b <= 1'b1;
                        double    <= 1'b1;
                        br_shadow <= 1'b1;
                    end
                    T_SHORT_IMM: begin
                        ctl.short_load <= 1'b1;
                    end
                    T_LONG_IMM: begin
                        ctl.long_load <= 1'b1;
                        double        <= 1'b1;  // Next word is the value
                    end
                    T_RAM_LOAD: begin
                        ctl.ram_load <= 1'b1;
                        br.pc_halt   <= 1'b1;
                        stall        <= 1'b1;
                    end
                    T_RAM_STORE: begin
                        ctl.ram_store <= 1'b1;
                        br.pc_halt    <= 1'b1;
                        stall         <= 1'b1;
                    end
                    default: begin
                        fault <= 1'b1;  // Undefined T runs as a no-op
                    end
                endcase
            end
        end
    end

    // Fields follow every word, only the strobes say when they count
    always_ff @(posedge clk) begin
        if (cen) begin
            br.ja         <= PC_W'(instr.jump.ja);
            ctl.y_field   <= instr.move.y;
            ctl.pm_sel    <= instr.move.pm;
            ctl.short_imm <= instr.word[SIMM_W-1:0];
            if (t_cls == T_SHORT_IMM) begin
                ctl.r_field <= instr.move.r_short;
            end else begin
                ctl.r_field <= instr.move.r_move;
            end
            if (stall) begin
                held_word <= rom_dout;
            end
        end
    end

endmodule

// ==== hdl/dsp16_fetch.sv ====
// DSP16 fetch stage
// Program counter, one-deep return register and branch selection
`timescale 1ns/1ns

module dsp16_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    dsp16_branch_if.fet               br,
    output logic [dsp16_pkg::PC_W-1:0] rom_addr
);
    import dsp16_pkg::*;

    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] pr;
    logic [PC_W-1:0] pc_next;
    logic [PC_W-1:0] ret_addr;

    // Strobes arrive two words after the branch was fetched
    assign ret_addr = pc - PC_W'(1);

    always_comb begin
        if (br.goto_b) begin
            pc_next = pr;               // return
        end else if (br.goto_ja || br.call_ja) begin
            pc_next = br.ja;
        end else if (br.pc_halt) begin
            pc_next = pc;               // RAM transfer bubble
        end else begin
            pc_next = pc + PC_W'(1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (cen) begin
            pc <= pc_next;
        end
    end

    // Only one level of subroutine is kept
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pr <= '0;
        end else if (cen && br.call_ja) begin
            pr <= ret_addr;  // Address of the call plus one
        end
    end

    assign rom_addr = pc;

endmodule

// ==== hdl/dsp16_pkg.sv ====
// DSP16 sequencer shared definitions
// Widths, T-field classes, register and post-modify codes, ROM word views
package dsp16_pkg;

    localparam int DATA_W = 16;  // Data and instruction word
    localparam int PC_W   = 12;  // Program address
    localparam int RAM_AW = 16;  // Data RAM address
    localparam int JA_W   = 10;  // Jump address field
    localparam int SIMM_W = 9;   // Short immediate field

    // T field classes, bit 0 is ignored for goto JA, short imm and call JA
    localparam logic [4:0] T_GOTO_JA   = 5'b00000;
    localparam logic [4:0] T_SHORT_IMM = 5'b00010;
    localparam logic [4:0] T_CALL_JA   = 5'b10000;
    localparam logic [4:0] T_GOTO_B    = 5'b11000;  // return through pr
    localparam logic [4:0] T_LONG_IMM  = 5'b01010;
    localparam logic [4:0] T_RAM_LOAD  = 5'b01111;  // R=Y
    localparam logic [4:0] T_RAM_STORE = 5'b01100;  // Y=R

    // YAAU register indices, 6 and 7 load nothing
    localparam logic [2:0] REG_R0 = 3'd0;
    localparam logic [2:0] REG_R1 = 3'd1;
    localparam logic [2:0] REG_R2 = 3'd2;
    localparam logic [2:0] REG_R3 = 3'd3;
    localparam logic [2:0] REG_J  = 3'd4;
    localparam logic [2:0] REG_K  = 3'd5;

    // Pointer post-modify
    localparam logic [1:0] PM_NONE   = 2'd0;  // *rN
    localparam logic [1:0] PM_INC    = 2'd1;  // *rN++
    localparam logic [1:0] PM_DEC    = 2'd2;  // *rN--
    localparam logic [1:0] PM_STEP_J = 2'd3;  // *rN++j

    typedef struct packed {
        logic [4:0]      t;
        logic            rsv;
        logic [JA_W-1:0] ja;
    } dsp16_jump_t;

    // Short immediate keeps its target at 11:9 and the value at 8:0
    typedef struct packed {
        logic [3:0] t_hi;
        logic [2:0] r_short;
        logic [1:0] rsv;
        logic [2:0] r_move;   // Long imm and RAM transfer target
        logic [1:0] y;
        logic [1:0] pm;
    } dsp16_move_t;

    typedef union packed {
        logic [DATA_W-1:0] word;
        dsp16_jump_t       jump;
        dsp16_move_t       move;
    } dsp16_instr_u;

endpackage

// ==== hdl/dsp16_top.sv ====
// DSP16 sequencer top
// Fetch, decode and Y address unit on plain ROM and RAM ports
`timescale 1ns/1ns

module dsp16_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cen,   // Freezes the pipeline when low
    // Program ROM, one cycle latency
    output logic [dsp16_pkg::PC_W-1:0]   rom_addr,
    input  logic [dsp16_pkg::DATA_W-1:0] rom_dout,
    // Data RAM
    output logic [dsp16_pkg::RAM_AW-1:0] ram_addr,
    output logic [dsp16_pkg::DATA_W-1:0] ram_wdata,
    output logic                         ram_we,
    output logic                         ram_rd,
    input  logic [dsp16_pkg::DATA_W-1:0] ram_rdata,
    output logic                         fault
);

    dsp16_branch_if br_if ();
    dsp16_ctrl_if   ctl_if ();

    dsp16_fetch i_fetch (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .br       (br_if),
        .rom_addr (rom_addr)
    );

    dsp16_decode i_decode (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rom_dout (rom_dout),
        .br       (br_if),
        .ctl      (ctl_if),
        .fault    (fault)
    );

    dsp16_yaau i_yaau (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ctl       (ctl_if),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rd    (ram_rd),
        .ram_rdata (ram_rdata)
    );

endmodule

// ==== hdl/dsp16_yaau.sv ====
// DSP16 Y address unit
// Pointers r0-r3, steps j and k, data RAM drive and post-modify
`timescale 1ns/1ns

module dsp16_yaau (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cen,
    dsp16_ctrl_if.exe                    ctl,
    output logic [dsp16_pkg::RAM_AW-1:0] ram_addr,
    output logic [dsp16_pkg::DATA_W-1:0] ram_wdata,
    output logic                         ram_we,
    output logic                         ram_rd,
    input  logic [dsp16_pkg::DATA_W-1:0] ram_rdata
);
    import dsp16_pkg::*;

    logic [DATA_W-1:0] ptr [4];
    logic [DATA_W-1:0] j;
    logic [DATA_W-1:0] k;
    logic [DATA_W-1:0] step;
    logic [DATA_W-1:0] ptr_next;
    logic              ld_pend;    // RAM data due this cycle
    logic [2:0]        ld_reg;
    logic              wr_en;
    logic [2:0]        wr_idx;
    logic [DATA_W-1:0] wr_val;

    always_comb begin
        case (ctl.pm_sel)
            PM_NONE:   step = '0;
            PM_INC:    step = DATA_W'(1);
            PM_DEC:    step = '1;
            PM_STEP_J: step = j;
        endcase
        ptr_next = ptr[ctl.y_field] + step;  // wraps at 16 bits
    end

    // Source register for a store
    always_comb begin
        case (ctl.r_field)
            REG_R0, REG_R1, REG_R2, REG_R3: ram_wdata = ptr[ctl.r_field[1:0]];
            REG_J:   ram_wdata = j;
            REG_K:   ram_wdata = k;
            default: ram_wdata = '0;
        endcase
    end

    assign ram_addr = RAM_AW'(ptr[ctl.y_field]);
    assign ram_we   = cen & ctl.ram_store;
    assign ram_rd   = cen & ctl.ram_load;

    // The three register write sources never overlap in time
    always_comb begin
        wr_en  = 1'b1;
        wr_idx = ctl.r_field;
        wr_val = '0;
        if (ld_pend) begin
            wr_idx = ld_reg;
            wr_val = ram_rdata;
        end else if (ctl.short_load) begin
            wr_val = {{(DATA_W-SIMM_W){ctl.short_imm[SIMM_W-1]}}, ctl.short_imm};
        end else if (ctl.long_load) begin
            wr_val = ctl.long_imm;
        end else begin
            wr_en = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr     <= '{default: '0};
            j       <= '0;
            k       <= '0;
            ld_pend <= 1'b0;
        end else if (cen) begin
            ld_pend <= ctl.ram_load;
            if (ctl.ram_load || ctl.ram_store) begin
                ptr[ctl.y_field] <= ptr_next;
            end
            if (wr_en) begin
                case (wr_idx)
                    REG_R0, REG_R1, REG_R2, REG_R3: ptr[wr_idx[1:0]] <= wr_val;
                    REG_J:   j <= wr_val;
                    REG_K:   k <= wr_val;
                    default: ;  // 6 and 7 are dropped
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && ctl.ram_load) begin
            ld_reg <= ctl.r_field;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f dsp16_seq.f --top-module dsp16_tb -o dsp16_sim \
    && ./obj_dir/dsp16_sim \
    || exit 1

// ==== sim/dsp16_props.sv ====
// DSP16 sequencer port properties
// RAM strobe exclusion, sticky fault and quiet outputs in reset
`timescale 1ns/1ns

module dsp16_props (
    input logic clk,
    input logic rst,
    input logic ram_we,
    input logic ram_rd,
    input logic fault
);

    a_we_rd_excl: assert property (@(posedge clk) disable iff (rst) !(ram_we && ram_rd))
        else $error("ram_we and ram_rd high in the same cycle");

    // Fault never clears outside reset
    a_fault_sticky: assert property (@(posedge clk) disable iff (rst) fault |=> fault)
        else $error("fault dropped after being raised");

    a_quiet_reset: assert property (@(posedge clk) rst |-> (!ram_we && !ram_rd && !fault))
        else $error("strobe or fault high during reset");

endmodule

bind dsp16_top dsp16_props i_props (
    .clk    (clk),
    .rst    (rst),
    .ram_we (ram_we),
    .ram_rd (ram_rd),
    .fault  (fault)
);

// ==== sim/dsp16_stim.txt ====
// Line 3 is the program length, then program words, then the write count,
// then one expected RAM write per line as address and data (all hex)
001C
1010 13FE 14A5 1803 // short imm r0, r1, r2, j
1B80 5030 BEEF 6030 // short imm k, long imm r3, *r0 = r3
6051 6042 6027 6014 // *r0++, *r0--, *r1++j wraps, *r1
7839 0010 6000 6000 // load r3 = *r2++, goto 16, two skipped stores
6038 8018 6021 F800 // call 24, return lands on 18, undefined T
0014 1C00 1C00 1C00 // park on goto 20
6046 C000 6000 6000 // subroutine *r1--, return, two skipped stores
0008
0010 BEEF
0010 FF80
0011 0003
FFFE 00A5
0001 0001
00A6 00A5
0001 0003
0010 00A6

// ==== sim/dsp16_tb.sv ====
// DSP16 sequencer testbench
// ROM and RAM models, random clock enable, RAM write trace and fault checks
`timescale 1ns/1ns

module dsp16_tb;
    import dsp16_pkg::*;

    localparam logic [DATA_W-1:0] NOP_WORD = 16'h1C00;  // Short imm into index 6
    localparam int STIM_DEPTH  = 256;
    localparam int TAIL_CYCLES = 32;  // Quiet window after the last write

    logic              clk;
    logic              rst       = 1'b1;
    logic              cen       = 1'b1;
    logic [PC_W-1:0]   rom_addr;
    logic [DATA_W-1:0] rom_dout  = NOP_WORD;
    logic [RAM_AW-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata;
    logic              ram_we;
    logic              ram_rd;
    logic [DATA_W-1:0] ram_rdata = '0;
    logic              fault;

    logic [DATA_W-1:0] stim [STIM_DEPTH];
    logic [DATA_W-1:0] rom  [2**PC_W];
    logic [DATA_W-1:0] ram  [2**RAM_AW];
    logic [31:0]       rnd_state   = 32'd57594;
    int                prog_len    = 0;
    int                trace_len   = 0;
    int                trace_base  = 0;
    int                wr_count    = 0;
    int                cycle_count = 0;
    int                cycle_limit = 0;

    dsp16_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .rom_addr  (rom_addr),
        .rom_dout  (rom_dout),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rd    (ram_rd),
        .ram_rdata (ram_rdata),
        .fault     (fault)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input string name, input logic [RAM_AW-1:0] exp,
                              input logic [RAM_AW-1:0] act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Clock enable high about three cycles in four
    always @(posedge clk) begin
        rnd_state = next_random(rnd_state);
        cen <= |rnd_state[1:0];
    end

    // Synchronous program ROM stalled by the clock enable
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_dout <= NOP_WORD;
        end else if (cen) begin
            rom_dout <= rom[rom_addr];
        end
    end

    always @(posedge clk) begin
        if (ram_we) ram[ram_addr] <= ram_wdata;
        if (ram_rd) ram_rdata <= ram[ram_addr];  // Held until the next read
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
            fail_run("Timeout: RAM write trace did not complete in time");
    end

    // RAM write trace on the falling edge
    always @(negedge clk) begin
        if (!rst && ram_we) begin
            if (wr_count >= trace_len) begin
                fail_run("Unexpected RAM write after the expected trace was complete");
            end else begin
                check_addr($sformatf("write_%0d_addr", wr_count),
                           stim[trace_base + 2*wr_count], ram_addr);
                check_data($sformatf("write_%0d_data", wr_count),
                           stim[trace_base + 2*wr_count + 1], ram_wdata);
                check_flag($sformatf("write_%0d_fault", wr_count), 1'b0, fault);
                wr_count++;
            end
        end
    end

    initial begin
        int i;
        for (i = 0; i < 2**PC_W; i++) rom[i] = NOP_WORD;
        for (i = 0; i < 2**RAM_AW; i++) ram[i] = DATA_W'(i);  // Data equals address
        $readmemh("sim/dsp16_stim.txt", stim);
        if ($isunknown(stim[0]) || stim[0] == '0)
            fail_run("Stimulus file missing or empty");
        prog_len = int'(stim[0]);
        for (i = 0; i < prog_len; i++) rom[i] = stim[1 + i];
        trace_len   = int'(stim[prog_len + 1]);
        trace_base  = prog_len + 2;
        cycle_limit = 8 * (prog_len + trace_len) * 4;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        while (wr_count < trace_len) @(posedge clk);
        repeat (TAIL_CYCLES) @(posedge clk);
        @(negedge clk);
        check_flag("fault_after_undefined_t", 1'b1, fault);
        $display("STATUS: PASS");
        $finish;
    end

endmodule
